/* hdl/axil_pkg.sv */
// AXI-Lite bus widths, payload types and response codes
`default_nettype none

package axil_pkg;

	localparam int ADDR_WIDTH = 32;
	localparam int DATA_WIDTH = 32;
	localparam int STRB_WIDTH = DATA_WIDTH / 8;

	typedef logic [ADDR_WIDTH-1:0] addr_t;
	typedef logic [DATA_WIDTH-1:0] data_t;
	typedef logic [STRB_WIDTH-1:0] strb_t;
	typedef logic [1:0]            resp_t;

	localparam resp_t RESP_OKAY   = 2'b00;
	localparam resp_t RESP_DECERR = 2'b11; // No slave at this address

endpackage

`default_nettype wire

/* hdl/soc_map_pkg.sv */
// System memory map: region indices, base addresses and region widths
`default_nettype none

package soc_map_pkg;

	localparam int REGION_COUNT = 3;

	localparam axil_pkg::addr_t SDRAM_BASE = 32'h0000_0000;
	localparam int unsigned     SDRAM_BITS = 25;
	localparam axil_pkg::addr_t GPU_BASE   = 32'h0200_0000;
	localparam int unsigned     GPU_BITS   = 8;
	localparam axil_pkg::addr_t BOOT_BASE  = 32'h0200_8000;
	localparam int unsigned     BOOT_BITS  = 15;
	localparam int unsigned     BOOT_WORDS = 8192; // 32 KiB of boot code

	// Values double as slot numbers in the router response mux
	typedef enum logic [1:0] {
		REGION_BOOT  = 2'd0,
		REGION_GPU   = 2'd1,
		REGION_SDRAM = 2'd2,
		REGION_NONE  = 2'd3
	} region_t;

endpackage

`default_nettype wire

/* hdl/reset_release.sv */
// Power-on reset hold counter
`timescale 1ns/1ps
`default_nettype none

module reset_release #(
	parameter int RESET_HOLD = 255
) (
	input  logic hdmi_pixClk,
	input  logic rst_n,
	output logic fabric_rst_n
);

	localparam int CNT_W = $clog2(RESET_HOLD + 1);

	logic [CNT_W-1:0] hold_cnt;

	always_ff @(posedge hdmi_pixClk or negedge rst_n) begin
		if (!rst_n) begin
			hold_cnt     <= '0;
			fabric_rst_n <= 1'b0;
		end else begin
			if (hold_cnt != CNT_W'(RESET_HOLD))
				hold_cnt <= hold_cnt + 1'b1;
			fabric_rst_n <= (hold_cnt == CNT_W'(RESET_HOLD)); // One cycle after the count ends
		end
	end

endmodule

`default_nettype wire

/* hdl/axil_arbiter.sv */
// Round-robin AXI-Lite master arbiter with whole-transaction lock
`timescale 1ns/1ps
`default_nettype none

module axil_arbiter (
	input  logic hdmi_pixClk,
	input  logic fabric_rst_n,

	input  axil_pkg::addr_t cpu_awaddr, cpu_araddr,
	input  axil_pkg::data_t cpu_wdata,
	input  axil_pkg::strb_t cpu_wstrb,
	input  logic cpu_awvalid, cpu_wvalid, cpu_bready, cpu_arvalid, cpu_rready,
	output logic cpu_awready, cpu_wready, cpu_bvalid, cpu_arready, cpu_rvalid,
	output axil_pkg::resp_t cpu_bresp, cpu_rresp,
	output axil_pkg::data_t cpu_rdata,

	input  axil_pkg::addr_t gfx_awaddr, gfx_araddr,
	input  axil_pkg::data_t gfx_wdata,
	input  axil_pkg::strb_t gfx_wstrb,
	input  logic gfx_awvalid, gfx_wvalid, gfx_bready, gfx_arvalid, gfx_rready,
	output logic gfx_awready, gfx_wready, gfx_bvalid, gfx_arready, gfx_rvalid,
	output axil_pkg::resp_t gfx_bresp, gfx_rresp,
	output axil_pkg::data_t gfx_rdata,

	output axil_pkg::addr_t arb_awaddr, arb_araddr,
	output axil_pkg::data_t arb_wdata,
	output axil_pkg::strb_t arb_wstrb,
	output logic arb_awvalid, arb_wvalid, arb_bready, arb_arvalid, arb_rready,
	input  logic arb_awready, arb_wready, arb_bvalid, arb_arready, arb_rvalid,
	input  axil_pkg::resp_t arb_bresp, arb_rresp,
	input  axil_pkg::data_t arb_rdata
);

	logic busy;     // A transaction is granted
	logic last_gfx; // Granted or last served master
	logic op_write;
	logic cpu_req, gfx_req, pick_gfx, txn_done;
	logic cpu_wr, cpu_rd, gfx_wr, gfx_rd;

	assign cpu_req  = cpu_awvalid | cpu_arvalid;
	assign gfx_req  = gfx_awvalid | gfx_arvalid;
	assign pick_gfx = gfx_req & (~cpu_req | ~last_gfx);
	assign txn_done = op_write ? (arb_bvalid & arb_bready) : (arb_rvalid & arb_rready);

	always_ff @(posedge hdmi_pixClk or negedge fabric_rst_n) begin
		if (!fabric_rst_n) begin
			busy     <= 1'b0;
			last_gfx <= 1'b1; // So cpu goes first
			op_write <= 1'b0;
		end else if (busy) begin
			if (txn_done)
				busy <= 1'b0;
		end else if (cpu_req | gfx_req) begin
			busy     <= 1'b1;
			last_gfx <= pick_gfx;
			op_write <= pick_gfx ? gfx_awvalid : cpu_awvalid; // Write wins within a master
		end
	end

	assign cpu_wr = busy & op_write & ~last_gfx;
	assign cpu_rd = busy & ~op_write & ~last_gfx;
	assign gfx_wr = busy & op_write & last_gfx;
	assign gfx_rd = busy & ~op_write & last_gfx;

	assign arb_awaddr  = last_gfx ? gfx_awaddr : cpu_awaddr;
	assign arb_araddr  = last_gfx ? gfx_araddr : cpu_araddr;
	assign arb_wdata   = last_gfx ? gfx_wdata : cpu_wdata;
	assign arb_wstrb   = last_gfx ? gfx_wstrb : cpu_wstrb;
	assign arb_awvalid = (cpu_wr & cpu_awvalid) | (gfx_wr & gfx_awvalid);
	assign arb_wvalid  = (cpu_wr & cpu_wvalid) | (gfx_wr & gfx_wvalid);
	assign arb_bready  = (cpu_wr & cpu_bready) | (gfx_wr & gfx_bready);
	assign arb_arvalid = (cpu_rd & cpu_arvalid) | (gfx_rd & gfx_arvalid);
	assign arb_rready  = (cpu_rd & cpu_rready) | (gfx_rd & gfx_rready);

	// Handshakes back to the granted master only
	assign cpu_awready = cpu_wr & arb_awready;
	assign cpu_wready  = cpu_wr & arb_wready;
	assign cpu_bvalid  = cpu_wr & arb_bvalid;
	assign cpu_arready = cpu_rd & arb_arready;
	assign cpu_rvalid  = cpu_rd & arb_rvalid;
	assign gfx_awready = gfx_wr & arb_awready;
	assign gfx_wready  = gfx_wr & arb_wready;
	assign gfx_bvalid  = gfx_wr & arb_bvalid;
	assign gfx_arready = gfx_rd & arb_arready;
	assign gfx_rvalid  = gfx_rd & arb_rvalid;

	assign cpu_bresp = arb_bresp;
	assign cpu_rresp = arb_rresp;
	assign cpu_rdata = arb_rdata;
	assign gfx_bresp = arb_bresp;
	assign gfx_rresp = arb_rresp;
	assign gfx_rdata = arb_rdata;

endmodule

`default_nettype wire

/* hdl/axil_addr_router.sv */
// AXI-Lite address decoder, slave routing and decode-error responder
`timescale 1ns/1ps
`default_nettype none

module axil_addr_router (
	input  logic hdmi_pixClk,
	input  logic fabric_rst_n,

	input  axil_pkg::addr_t arb_awaddr, arb_araddr,
	input  axil_pkg::data_t arb_wdata,
	input  axil_pkg::strb_t arb_wstrb,
	input  logic arb_awvalid, arb_wvalid, arb_bready, arb_arvalid, arb_rready,
	output logic arb_awready, arb_wready, arb_bvalid, arb_arready, arb_rvalid,
	output axil_pkg::resp_t arb_bresp, arb_rresp,
	output axil_pkg::data_t arb_rdata,

	output axil_pkg::addr_t boot_awaddr, boot_araddr,
	output axil_pkg::data_t boot_wdata,
	output axil_pkg::strb_t boot_wstrb,
	output logic boot_awvalid, boot_wvalid, boot_bready, boot_arvalid, boot_rready,
	input  logic boot_awready, boot_wready, boot_bvalid, boot_arready, boot_rvalid,
	input  axil_pkg::resp_t boot_bresp, boot_rresp,
	input  axil_pkg::data_t boot_rdata,

	output axil_pkg::addr_t gpu_awaddr, gpu_araddr,
	output axil_pkg::data_t gpu_wdata,
	output axil_pkg::strb_t gpu_wstrb,
	output logic gpu_awvalid, gpu_wvalid, gpu_bready, gpu_arvalid, gpu_rready,
	input  logic gpu_awready, gpu_wready, gpu_bvalid, gpu_arready, gpu_rvalid,
	input  axil_pkg::resp_t gpu_bresp, gpu_rresp,
	input  axil_pkg::data_t gpu_rdata,

	output axil_pkg::addr_t sdram_awaddr, sdram_araddr,
	output axil_pkg::data_t sdram_wdata,
	output axil_pkg::strb_t sdram_wstrb,
	output logic sdram_awvalid, sdram_wvalid, sdram_bready, sdram_arvalid, sdram_rready,
	input  logic sdram_awready, sdram_wready, sdram_bvalid, sdram_arready, sdram_rvalid,
	input  axil_pkg::resp_t sdram_bresp, sdram_rresp,
	input  axil_pkg::data_t sdram_rdata
);

	import axil_pkg::*;
	import soc_map_pkg::*;

	localparam int PORTS = REGION_COUNT + 1; // Slaves plus error responder

	region_t dec_region, route_q, cur;
	logic route_hold, txn_done;
	addr_t req_addr;
	logic [PORTS-1:0] sel;
	logic [PORTS-1:0] s_awready, s_wready, s_bvalid, s_arready, s_rvalid;
	resp_t [PORTS-1:0] s_bresp, s_rresp;
	data_t [PORTS-1:0] s_rdata;
	logic err_aw_done, err_w_done, err_bvalid, err_rvalid;
	logic err_awready, err_wready, err_arready;
	logic err_aw_fire, err_w_fire, err_ar_fire;

	function automatic logic region_hit(addr_t addr, addr_t base, int unsigned bits);
		return (addr >> bits) == (base >> bits);
	endfunction

	assign req_addr = arb_awvalid ? arb_awaddr : arb_araddr;

	always_comb begin
		if (region_hit(req_addr, BOOT_BASE, BOOT_BITS))
			dec_region = REGION_BOOT;
		else if (region_hit(req_addr, GPU_BASE, GPU_BITS))
			dec_region = REGION_GPU;
		else if (region_hit(req_addr, SDRAM_BASE, SDRAM_BITS))
			dec_region = REGION_SDRAM;
		else
			dec_region = REGION_NONE;
	end

	// Region is latched on the first valid, the master may move its address after aw
	assign txn_done = (arb_bvalid & arb_bready) | (arb_rvalid & arb_rready);
	always_ff @(posedge hdmi_pixClk or negedge fabric_rst_n) begin
		if (!fabric_rst_n) begin
			route_hold <= 1'b0;
			route_q    <= REGION_NONE;
		end else if (txn_done) begin
			route_hold <= 1'b0;
		end else if (!route_hold && (arb_awvalid || arb_arvalid)) begin
			route_hold <= 1'b1;
			route_q    <= dec_region;
		end
	end

	assign cur = route_hold ? route_q : dec_region;
	assign sel = PORTS'(1) << cur;

	assign {boot_awaddr, gpu_awaddr, sdram_awaddr} = {3{arb_awaddr}};
	assign {boot_araddr, gpu_araddr, sdram_araddr} = {3{arb_araddr}};
	assign {boot_wdata, gpu_wdata, sdram_wdata}    = {3{arb_wdata}};
	assign {boot_wstrb, gpu_wstrb, sdram_wstrb}    = {3{arb_wstrb}};

	assign boot_awvalid  = arb_awvalid & sel[REGION_BOOT];
	assign boot_wvalid   = arb_wvalid & sel[REGION_BOOT];
	assign boot_bready   = arb_bready & sel[REGION_BOOT];
	assign boot_arvalid  = arb_arvalid & sel[REGION_BOOT];
	assign boot_rready   = arb_rready & sel[REGION_BOOT];
	assign gpu_awvalid   = arb_awvalid & sel[REGION_GPU];
	assign gpu_wvalid    = arb_wvalid & sel[REGION_GPU];
	assign gpu_bready    = arb_bready & sel[REGION_GPU];
	assign gpu_arvalid   = arb_arvalid & sel[REGION_GPU];
	assign gpu_rready    = arb_rready & sel[REGION_GPU];
	assign sdram_awvalid = arb_awvalid & sel[REGION_SDRAM];
	assign sdram_wvalid  = arb_wvalid & sel[REGION_SDRAM];
	assign sdram_bready  = arb_bready & sel[REGION_SDRAM];
	assign sdram_arvalid = arb_arvalid & sel[REGION_SDRAM];
	assign sdram_rready  = arb_rready & sel[REGION_SDRAM];

	// Slot order follows region_t
	assign s_awready = {err_awready, sdram_awready, gpu_awready, boot_awready};
	assign s_wready  = {err_wready, sdram_wready, gpu_wready, boot_wready};
	assign s_bvalid  = {err_bvalid, sdram_bvalid, gpu_bvalid, boot_bvalid};
	assign s_arready = {err_arready, sdram_arready, gpu_arready, boot_arready};
	assign s_rvalid  = {err_rvalid, sdram_rvalid, gpu_rvalid, boot_rvalid};
	assign s_bresp   = {RESP_DECERR, sdram_bresp, gpu_bresp, boot_bresp};
	assign s_rresp   = {RESP_DECERR, sdram_rresp, gpu_rresp, boot_rresp};
	assign s_rdata   = {data_t'(0), sdram_rdata, gpu_rdata, boot_rdata};

	assign arb_awready = s_awready[cur];
	assign arb_wready  = s_wready[cur];
	assign arb_bvalid  = s_bvalid[cur];
	assign arb_bresp   = s_bresp[cur];
	assign arb_arready = s_arready[cur];
	assign arb_rvalid  = s_rvalid[cur];
	assign arb_rresp   = s_rresp[cur];
	assign arb_rdata   = s_rdata[cur];

	// Error responder for unmapped addresses
	assign err_awready = ~err_aw_done & ~err_bvalid;
	assign err_wready  = ~err_w_done & ~err_bvalid;
	assign err_arready = ~err_rvalid;
	assign err_aw_fire = sel[REGION_NONE] & arb_awvalid & err_awready;
	assign err_w_fire  = sel[REGION_NONE] & arb_wvalid & err_wready;
	assign err_ar_fire = sel[REGION_NONE] & arb_arvalid & err_arready;

	always_ff @(posedge hdmi_pixClk or negedge fabric_rst_n) begin
		if (!fabric_rst_n) begin
			err_aw_done <= 1'b0;
			err_w_done  <= 1'b0;
			err_bvalid  <= 1'b0;
			err_rvalid  <= 1'b0;
		end else begin
			if (err_bvalid && arb_bready && sel[REGION_NONE]) begin
				err_bvalid <= 1'b0;
			end else if ((err_aw_done || err_aw_fire) && (err_w_done || err_w_fire)) begin
				err_bvalid  <= 1'b1; // aw and w in either order
				err_aw_done <= 1'b0;
				err_w_done  <= 1'b0;
			end else begin
				err_aw_done <= err_aw_done | err_aw_fire;
				err_w_done  <= err_w_done | err_w_fire;
			end
			if (err_ar_fire)
				err_rvalid <= 1'b1;
			else if (err_rvalid && arb_rready && sel[REGION_NONE])
				err_rvalid <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* hdl/boot_ram.sv */
// AXI-Lite boot memory with byte strobes
`timescale 1ns/1ps
`default_nettype none

module boot_ram (
	input  logic hdmi_pixClk,
	input  logic fabric_rst_n,

	input  axil_pkg::addr_t boot_awaddr, boot_araddr,
	input  axil_pkg::data_t boot_wdata,
	input  axil_pkg::strb_t boot_wstrb,
	input  logic boot_awvalid, boot_wvalid, boot_bready, boot_arvalid, boot_rready,
	output logic boot_awready, boot_wready, boot_bvalid, boot_arready, boot_rvalid,
	output axil_pkg::resp_t boot_bresp, boot_rresp,
	output axil_pkg::data_t boot_rdata
);

	import axil_pkg::*;
	import soc_map_pkg::*;

	data_t mem [BOOT_WORDS];
	logic [BOOT_BITS-3:0] wr_idx, rd_idx; // Word index within the region
	logic wr_fire, rd_fire;

	assign boot_awready = boot_awvalid & boot_wvalid & ~boot_bvalid; // aw and w taken together
	assign boot_wready  = boot_awready;
	assign boot_arready = ~boot_rvalid;
	assign boot_bresp   = RESP_OKAY;
	assign boot_rresp   = RESP_OKAY;

	assign wr_fire = boot_awready;
	assign rd_fire = boot_arvalid & boot_arready;
	assign wr_idx  = boot_awaddr[BOOT_BITS-1:2];
	assign rd_idx  = boot_araddr[BOOT_BITS-1:2];

	always_ff @(posedge hdmi_pixClk) begin
		if (wr_fire) begin
			for (int b = 0; b < STRB_WIDTH; b++) begin
				if (boot_wstrb[b])
					mem[wr_idx][8*b +: 8] <= boot_wdata[8*b +: 8];
			end
		end
		if (rd_fire)
			boot_rdata <= mem[rd_idx]; // Held until the next accepted read
	end

	always_ff @(posedge hdmi_pixClk or negedge fabric_rst_n) begin
		if (!fabric_rst_n) begin
			boot_bvalid <= 1'b0;
			boot_rvalid <= 1'b0;
		end else begin
			if (wr_fire)
				boot_bvalid <= 1'b1;
			else if (boot_bready)
				boot_bvalid <= 1'b0;
			if (rd_fire)
				boot_rvalid <= 1'b1;
			else if (boot_rready)
				boot_rvalid <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* hdl/soc_fabric.sv */
// System bus fabric top: reset hold, master arbiter, address router and boot memory
`timescale 1ns/1ps
`default_nettype none

module soc_fabric #(
	parameter int RESET_HOLD = 255
) (
	input  logic hdmi_pixClk,
	input  logic rst_n,

	input  axil_pkg::addr_t cpu_awaddr, cpu_araddr,
	input  axil_pkg::data_t cpu_wdata,
	input  axil_pkg::strb_t cpu_wstrb,
	input  logic cpu_awvalid, cpu_wvalid, cpu_bready, cpu_arvalid, cpu_rready,
	output logic cpu_awready, cpu_wready, cpu_bvalid, cpu_arready, cpu_rvalid,
	output axil_pkg::resp_t cpu_bresp, cpu_rresp,
	output axil_pkg::data_t cpu_rdata,

	input  axil_pkg::addr_t gfx_awaddr, gfx_araddr,
	input  axil_pkg::data_t gfx_wdata,
	input  axil_pkg::strb_t gfx_wstrb,
	input  logic gfx_awvalid, gfx_wvalid, gfx_bready, gfx_arvalid, gfx_rready,
	output logic gfx_awready, gfx_wready, gfx_bvalid, gfx_arready, gfx_rvalid,
	output axil_pkg::resp_t gfx_bresp, gfx_rresp,
	output axil_pkg::data_t gfx_rdata,

	output axil_pkg::addr_t sdram_awaddr, sdram_araddr,
	output axil_pkg::data_t sdram_wdata,
	output axil_pkg::strb_t sdram_wstrb,
	output logic sdram_awvalid, sdram_wvalid, sdram_bready, sdram_arvalid, sdram_rready,
	input  logic sdram_awready, sdram_wready, sdram_bvalid, sdram_arready, sdram_rvalid,
	input  axil_pkg::resp_t sdram_bresp, sdram_rresp,
	input  axil_pkg::data_t sdram_rdata,

	output axil_pkg::addr_t gpu_awaddr, gpu_araddr,
	output axil_pkg::data_t gpu_wdata,
	output axil_pkg::strb_t gpu_wstrb,
	output logic gpu_awvalid, gpu_wvalid, gpu_bready, gpu_arvalid, gpu_rready,
	input  logic gpu_awready, gpu_wready, gpu_bvalid, gpu_arready, gpu_rvalid,
	input  axil_pkg::resp_t gpu_bresp, gpu_rresp,
	input  axil_pkg::data_t gpu_rdata
);

	import axil_pkg::*;

	logic fabric_rst_n;

	// Arbiter to router
	addr_t arb_awaddr, arb_araddr;
	data_t arb_wdata, arb_rdata;
	strb_t arb_wstrb;
	resp_t arb_bresp, arb_rresp;
	logic arb_awvalid, arb_awready, arb_wvalid, arb_wready, arb_bvalid, arb_bready;
	logic arb_arvalid, arb_arready, arb_rvalid, arb_rready;

	// Router to boot memory
	addr_t boot_awaddr, boot_araddr;
	data_t boot_wdata, boot_rdata;
	strb_t boot_wstrb;
	resp_t boot_bresp, boot_rresp;
	logic boot_awvalid, boot_awready, boot_wvalid, boot_wready, boot_bvalid, boot_bready;
	logic boot_arvalid, boot_arready, boot_rvalid, boot_rready;

	reset_release #(
		.RESET_HOLD(RESET_HOLD)
	) u_reset_release (.*);

	axil_arbiter u_axil_arbiter (.*);

	axil_addr_router u_axil_addr_router (.*);

	boot_ram u_boot_ram (.*);

endmodule

`default_nettype wire

/* sim/soc_fabric_assert.sv */
// Concurrent checks on the fabric ports: reset quiet, response hold, routing
`timescale 1ns/1ps
`default_nettype none

module soc_fabric_assert (
	input  logic hdmi_pixClk,
	input  logic fabric_rst_n,
	input  logic cpu_awready, cpu_wready, cpu_bvalid, cpu_bready, cpu_arready,
	input  logic cpu_rvalid, cpu_rready,
	input  axil_pkg::resp_t cpu_bresp, cpu_rresp,
	input  axil_pkg::data_t cpu_rdata,
	input  logic gfx_awready, gfx_wready, gfx_bvalid, gfx_bready, gfx_arready,
	input  logic gfx_rvalid, gfx_rready,
	input  axil_pkg::resp_t gfx_bresp, gfx_rresp,
	input  axil_pkg::data_t gfx_rdata,
	input  axil_pkg::addr_t sdram_awaddr, sdram_araddr, gpu_awaddr, gpu_araddr,
	input  logic sdram_awvalid, sdram_wvalid, sdram_bready, sdram_arvalid, sdram_rready,
	input  logic gpu_awvalid, gpu_wvalid, gpu_bready, gpu_arvalid, gpu_rready
);

	import axil_pkg::*;
	import soc_map_pkg::*;

	logic tripped = 1'b0;

	function automatic logic in_window(addr_t addr, addr_t base, int unsigned bits);
		addr_t mask;
		mask = ~((addr_t'(1) << bits) - 1'b1); // Clears the offset bits
		return (addr & mask) == base;
	endfunction

	a_quiet_in_reset: assert property (@(posedge hdmi_pixClk) !fabric_rst_n |-> !(
		cpu_awready | cpu_wready | cpu_bvalid | cpu_arready | cpu_rvalid |
		gfx_awready | gfx_wready | gfx_bvalid | gfx_arready | gfx_rvalid |
		sdram_awvalid | sdram_wvalid | sdram_bready | sdram_arvalid | sdram_rready |
		gpu_awvalid | gpu_wvalid | gpu_bready | gpu_arvalid | gpu_rready))
	else begin
		$error("Handshake output high while the fabric is in reset");
		tripped = 1'b1;
	end

	// Responses hold under back-pressure
	a_cpu_b_hold: assert property (@(posedge hdmi_pixClk) disable iff (!fabric_rst_n)
		cpu_bvalid && !cpu_bready |=> cpu_bvalid && $stable(cpu_bresp))
	else begin
		$error("cpu b channel changed while stalled");
		tripped = 1'b1;
	end
	a_cpu_r_hold: assert property (@(posedge hdmi_pixClk) disable iff (!fabric_rst_n)
		cpu_rvalid && !cpu_rready |=> cpu_rvalid && $stable({cpu_rresp, cpu_rdata}))
	else begin
		$error("cpu r channel changed while stalled");
		tripped = 1'b1;
	end
	a_gfx_b_hold: assert property (@(posedge hdmi_pixClk) disable iff (!fabric_rst_n)
		gfx_bvalid && !gfx_bready |=> gfx_bvalid && $stable(gfx_bresp))
	else begin
		$error("gfx b channel changed while stalled");
		tripped = 1'b1;
	end
	a_gfx_r_hold: assert property (@(posedge hdmi_pixClk) disable iff (!fabric_rst_n)
		gfx_rvalid && !gfx_rready |=> gfx_rvalid && $stable({gfx_rresp, gfx_rdata}))
	else begin
		$error("gfx r channel changed while stalled");
		tripped = 1'b1;
	end

	a_sdram_route: assert property (@(posedge hdmi_pixClk)
		(sdram_awvalid -> in_window(sdram_awaddr, SDRAM_BASE, SDRAM_BITS)) &&
		(sdram_arvalid -> in_window(sdram_araddr, SDRAM_BASE, SDRAM_BITS)))
	else begin
		$error("SDRAM port valid for an address outside its region");
		tripped = 1'b1;
	end
	a_gpu_route: assert property (@(posedge hdmi_pixClk)
		(gpu_awvalid -> in_window(gpu_awaddr, GPU_BASE, GPU_BITS)) &&
		(gpu_arvalid -> in_window(gpu_araddr, GPU_BASE, GPU_BITS)))
	else begin
		$error("GPU port valid for an address outside its region");
		tripped = 1'b1;
	end

endmodule

`default_nettype wire

/* sim/tb_soc_fabric.sv */
// Testbench for soc_fabric: master models, slave responders and the test sequence
`timescale 1ns/1ps
`default_nettype none

module axil_master_model (
	input  logic clk,
	output axil_pkg::addr_t awaddr, araddr,
	output axil_pkg::data_t wdata,
	output axil_pkg::strb_t wstrb,
	output logic awvalid, wvalid, bready, arvalid, rready,
	input  logic awready, wready, bvalid, arready, rvalid,
	input  axil_pkg::resp_t bresp, rresp,
	input  axil_pkg::data_t rdata
);

	import axil_pkg::*;

	initial begin
		awaddr = '0;
		araddr = '0;
		wdata = '0;
		wstrb = '0;
		{awvalid, wvalid, bready, arvalid, rready} = '0;
	end

	task automatic write_txn(input addr_t a, input data_t d, input strb_t s,
			input int stall, output resp_t r);
		bit aw_ok, w_ok, aw_hit, w_hit;
		aw_ok = 0;
		w_ok = 0;
		@(posedge clk);
		awaddr <= a;
		wdata <= d;
		wstrb <= s;
		awvalid <= 1'b1;
		wvalid <= 1'b1;
		while (!(aw_ok && w_ok)) begin
			@(negedge clk);
			aw_hit = awvalid && awready;
			w_hit = wvalid && wready;
			@(posedge clk);
			if (aw_hit) begin
				awvalid <= 1'b0;
				aw_ok = 1;
			end
			if (w_hit) begin
				wvalid <= 1'b0;
				w_ok = 1;
			end
		end
		do @(negedge clk); while (!bvalid);
		repeat (stall) @(negedge clk); // bready low, response must hold
		@(posedge clk);
		bready <= 1'b1;
		@(negedge clk);
		r = bresp;
		@(posedge clk);
		bready <= 1'b0;
	endtask

	task automatic read_txn(input addr_t a, input int stall, output data_t d, output resp_t r);
		@(posedge clk);
		araddr <= a;
		arvalid <= 1'b1;
		do @(negedge clk); while (!arready);
		@(posedge clk);
		arvalid <= 1'b0;
		do @(negedge clk); while (!rvalid);
		repeat (stall) @(negedge clk);
		@(posedge clk);
		rready <= 1'b1;
		@(negedge clk);
		d = rdata;
		r = rresp;
		@(posedge clk);
		rready <= 1'b0;
	endtask

endmodule

// External slave, answers one cycle after acceptance, read data is the address inverted
module axil_slave_model (
	input  logic clk,
	input  logic rst_n,
	input  axil_pkg::addr_t awaddr, araddr,
	input  axil_pkg::data_t wdata,
	input  axil_pkg::strb_t wstrb,
	input  logic awvalid, wvalid, bready, arvalid, rready,
	output logic awready, wready, bvalid, arready, rvalid,
	output axil_pkg::resp_t bresp, rresp,
	output axil_pkg::data_t rdata
);

	import axil_pkg::*;

	int wr_count, rd_count;
	addr_t last_awaddr, last_araddr;
	data_t last_wdata;
	strb_t last_wstrb;

	assign bresp = RESP_OKAY;
	assign rresp = RESP_OKAY;

	initial begin
		{awready, wready, bvalid, arready, rvalid} = '0;
		rdata = '0;
		forever begin
			@(posedge clk or negedge rst_n);
			if (!rst_n) begin
				{awready, wready, bvalid, arready, rvalid} <= '0;
				rdata <= '0;
				wr_count <= 0;
				rd_count <= 0;
			end else begin
				awready <= 1'b0;
				wready <= 1'b0;
				arready <= 1'b0;
				if (awready) begin // aw and w taken on this edge
					bvalid <= 1'b1;
					wr_count <= wr_count + 1;
					last_awaddr <= awaddr;
					last_wdata <= wdata;
					last_wstrb <= wstrb;
				end else if (bvalid && bready) begin
					bvalid <= 1'b0;
				end else if (awvalid && wvalid && !bvalid) begin
					awready <= 1'b1;
					wready <= 1'b1;
				end
				if (arready) begin
					rvalid <= 1'b1;
					rdata <= ~araddr;
					rd_count <= rd_count + 1;
					last_araddr <= araddr;
				end else if (rvalid && rready) begin
					rvalid <= 1'b0;
				end else if (arvalid && !rvalid) begin
					arready <= 1'b1;
				end
			end
		end
	end

endmodule

module tb_soc_fabric;

	import axil_pkg::*;
	import soc_map_pkg::*;

	localparam int RESET_HOLD = 20;
	localparam int TXN_COUNT = 69; // 9 arbitration, 48 boot, 8 external, 4 unmapped
	localparam int WATCHDOG_CYCLES = TXN_COUNT * 40 + 5 + RESET_HOLD + 2;
	localparam int BOOT_SLOTS = 16;

	logic hdmi_pixClk, rst_n;

	addr_t cpu_awaddr, cpu_araddr, gfx_awaddr, gfx_araddr;
	data_t cpu_wdata, cpu_rdata, gfx_wdata, gfx_rdata;
	strb_t cpu_wstrb, gfx_wstrb;
	resp_t cpu_bresp, cpu_rresp, gfx_bresp, gfx_rresp;
	logic cpu_awvalid, cpu_wvalid, cpu_bready, cpu_arvalid, cpu_rready;
	logic cpu_awready, cpu_wready, cpu_bvalid, cpu_arready, cpu_rvalid;
	logic gfx_awvalid, gfx_wvalid, gfx_bready, gfx_arvalid, gfx_rready;
	logic gfx_awready, gfx_wready, gfx_bvalid, gfx_arready, gfx_rvalid;

	addr_t sdram_awaddr, sdram_araddr, gpu_awaddr, gpu_araddr;
	data_t sdram_wdata, sdram_rdata, gpu_wdata, gpu_rdata;
	strb_t sdram_wstrb, gpu_wstrb;
	resp_t sdram_bresp, sdram_rresp, gpu_bresp, gpu_rresp;
	logic sdram_awvalid, sdram_wvalid, sdram_bready, sdram_arvalid, sdram_rready;
	logic sdram_awready, sdram_wready, sdram_bvalid, sdram_arready, sdram_rvalid;
	logic gpu_awvalid, gpu_wvalid, gpu_bready, gpu_arvalid, gpu_rready;
	logic gpu_awready, gpu_wready, gpu_bvalid, gpu_arready, gpu_rvalid;

	logic [31:0] rng_state = 32'd2180;
	data_t ref_mem [BOOT_SLOTS];

	soc_fabric #(
		.RESET_HOLD(RESET_HOLD)
	) u_soc_fabric (.*);

	bind soc_fabric soc_fabric_assert u_fabric_assert (.*);

	axil_master_model cpu_m (
		.clk(hdmi_pixClk),
		.awaddr(cpu_awaddr), .araddr(cpu_araddr), .wdata(cpu_wdata), .wstrb(cpu_wstrb),
		.awvalid(cpu_awvalid), .wvalid(cpu_wvalid), .bready(cpu_bready),
		.arvalid(cpu_arvalid), .rready(cpu_rready),
		.awready(cpu_awready), .wready(cpu_wready), .bvalid(cpu_bvalid),
		.arready(cpu_arready), .rvalid(cpu_rvalid),
		.bresp(cpu_bresp), .rresp(cpu_rresp), .rdata(cpu_rdata)
	);

	axil_master_model gfx_m (
		.clk(hdmi_pixClk),
		.awaddr(gfx_awaddr), .araddr(gfx_araddr), .wdata(gfx_wdata), .wstrb(gfx_wstrb),
		.awvalid(gfx_awvalid), .wvalid(gfx_wvalid), .bready(gfx_bready),
		.arvalid(gfx_arvalid), .rready(gfx_rready),
		.awready(gfx_awready), .wready(gfx_wready), .bvalid(gfx_bvalid),
		.arready(gfx_arready), .rvalid(gfx_rvalid),
		.bresp(gfx_bresp), .rresp(gfx_rresp), .rdata(gfx_rdata)
	);

	axil_slave_model sdram_s (
		.clk(hdmi_pixClk), .rst_n(rst_n),
		.awaddr(sdram_awaddr), .araddr(sdram_araddr), .wdata(sdram_wdata),
		.wstrb(sdram_wstrb),
		.awvalid(sdram_awvalid), .wvalid(sdram_wvalid), .bready(sdram_bready),
		.arvalid(sdram_arvalid), .rready(sdram_rready),
		.awready(sdram_awready), .wready(sdram_wready), .bvalid(sdram_bvalid),
		.arready(sdram_arready), .rvalid(sdram_rvalid),
		.bresp(sdram_bresp), .rresp(sdram_rresp), .rdata(sdram_rdata)
	);

	axil_slave_model gpu_s (
		.clk(hdmi_pixClk), .rst_n(rst_n),
		.awaddr(gpu_awaddr), .araddr(gpu_araddr), .wdata(gpu_wdata), .wstrb(gpu_wstrb),
		.awvalid(gpu_awvalid), .wvalid(gpu_wvalid), .bready(gpu_bready),
		.arvalid(gpu_arvalid), .rready(gpu_rready),
		.awready(gpu_awready), .wready(gpu_wready), .bvalid(gpu_bvalid),
		.arready(gpu_arready), .rvalid(gpu_rvalid),
		.bresp(gpu_bresp), .rresp(gpu_rresp), .rdata(gpu_rdata)
	);

	initial begin
		hdmi_pixClk = 1'b0;
		forever #2 hdmi_pixClk = ~hdmi_pixClk;
	end

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("Done: errors found");
		$fatal(1);
	endtask

	task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			stop_with_failure($sformatf("FAILED %0t: %s: got %h, expected %h",
				$time, what, got, exp));
	endtask

	function automatic logic [31:0] next_rand();
		rng_state ^= rng_state << 13;
		rng_state ^= rng_state >> 17;
		rng_state ^= rng_state << 5;
		return rng_state;
	endfunction

	function automatic int slave_total();
		return sdram_s.wr_count + sdram_s.rd_count + gpu_s.wr_count + gpu_s.rd_count;
	endfunction

	task automatic do_write(input int m, input addr_t a, input data_t d, input strb_t s,
			input int stall, output resp_t r);
		if (m == 0)
			cpu_m.write_txn(a, d, s, stall, r);
		else
			gfx_m.write_txn(a, d, s, stall, r);
	endtask

	task automatic do_read(input int m, input addr_t a, input int stall,
			output data_t d, output resp_t r);
		if (m == 0)
			cpu_m.read_txn(a, stall, d, r);
		else
			gfx_m.read_txn(a, stall, d, r);
	endtask

	// Both masters request together, the valids wait out the reset hold on round 0
	task automatic run_arbitration();
		data_t d0, d1;
		resp_t r0, r1;
		addr_t a0, a1;
		int order[$];
		int last_served;
		last_served = 1; // Reset state, so cpu takes the first tie
		for (int k = 0; k < 4; k++) begin
			if (k == 2) begin
				// cpu alone, the next tie goes to gfx
				cpu_m.read_txn(GPU_BASE + 32'h40, 0, d0, r0);
				check_value("cpu single read data", d0, ~(GPU_BASE + 32'h40));
				last_served = 0;
			end
			a0 = GPU_BASE + 32'(8 * k);
			a1 = a0 + 32'd4;
			fork
				begin
					cpu_m.read_txn(a0, 0, d0, r0);
					order.push_back(0);
				end
				begin
					gfx_m.read_txn(a1, 0, d1, r1);
					order.push_back(1);
				end
			join
			check_value("cpu gpu read data", d0, ~a0);
			check_value("gfx gpu read data", d1, ~a1);
			check_value("cpu gpu read resp", r0, RESP_OKAY);
			check_value("gfx gpu read resp", r1, RESP_OKAY);
			check_value($sformatf("round %0d first completion", k), order[2*k],
				1 - last_served);
			check_value($sformatf("round %0d second completion", k), order[2*k+1],
				last_served);
		end
	endtask

	task automatic run_boot();
		addr_t a;
		data_t d, rd;
		strb_t s;
		resp_t r;
		int i;
		for (int n = 0; n < BOOT_SLOTS; n++) begin
			a = BOOT_BASE + 32'((n * 517) % BOOT_WORDS) * 4;
			d = next_rand();
			do_write(n % 2, a, d, 4'hF, 0, r);
			check_value("boot fill resp", r, RESP_OKAY);
			ref_mem[n] = d;
		end
		for (int j = 0; j < BOOT_SLOTS; j++) begin
			i = next_rand() % BOOT_SLOTS;
			a = BOOT_BASE + 32'((i * 517) % BOOT_WORDS) * 4;
			d = next_rand();
			s = strb_t'(next_rand());
			do_write(j % 2, a, d, s, j % 3, r);
			check_value("boot strobe write resp", r, RESP_OKAY);
			for (int b = 0; b < STRB_WIDTH; b++)
				if (s[b])
					ref_mem[i][8*b +: 8] = d[8*b +: 8];
		end
		for (int n = 0; n < BOOT_SLOTS; n++) begin
			a = BOOT_BASE + 32'((n * 517) % BOOT_WORDS) * 4;
			do_read((n + 1) % 2, a, n % 3, rd, r);
			check_value($sformatf("boot read at %h", a), rd, ref_mem[n]);
			check_value("boot read resp", r, RESP_OKAY);
		end
	endtask

	task automatic run_external();
		addr_t a;
		data_t d, rd;
		strb_t s;
		resp_t r;
		int total, wr_before, rd_before;
		for (int m = 0; m < 2; m++) begin
			for (int g = 0; g < 2; g++) begin
				a = (g == 0) ? SDRAM_BASE + 32'h0010_0000 + 32'(m * 64) : GPU_BASE + 32'(m * 4);
				d = next_rand();
				s = strb_t'(next_rand());
				total = slave_total();
				wr_before = (g == 0) ? sdram_s.wr_count : gpu_s.wr_count;
				rd_before = (g == 0) ? sdram_s.rd_count : gpu_s.rd_count;
				do_write(m, a, d, s, 1, r);
				check_value("external write resp", r, RESP_OKAY);
				check_value("slave transfers after write", slave_total(), total + 1);
				check_value("region write count",
					(g == 0) ? sdram_s.wr_count : gpu_s.wr_count, wr_before + 1);
				check_value("slave awaddr",
					(g == 0) ? sdram_s.last_awaddr : gpu_s.last_awaddr, a);
				check_value("slave wdata", (g == 0) ? sdram_s.last_wdata : gpu_s.last_wdata, d);
				check_value("slave wstrb", (g == 0) ? sdram_s.last_wstrb : gpu_s.last_wstrb, s);
				do_read(m, a, 2, rd, r);
				check_value("external read data", rd, ~a);
				check_value("external read resp", r, RESP_OKAY);
				check_value("slave transfers after read", slave_total(), total + 2);
				check_value("region read count",
					(g == 0) ? sdram_s.rd_count : gpu_s.rd_count, rd_before + 1);
				check_value("slave araddr",
					(g == 0) ? sdram_s.last_araddr : gpu_s.last_araddr, a);
			end
		end
	endtask

	task automatic run_unmapped();
		addr_t a;
		data_t rd;
		resp_t r;
		int total;
		for (int m = 0; m < 2; m++) begin
			a = 32'h0300_0000 + 32'(m * 4);
			total = slave_total();
			do_write(m, a, next_rand(), 4'hF, m, r);
			check_value("unmapped write resp", r, RESP_DECERR);
			do_read(m, a, m, rd, r);
			check_value("unmapped read resp", r, RESP_DECERR);
			check_value("unmapped read data", rd, 32'h0);
			check_value("slave transfers on unmapped access", slave_total(), total);
		end
	endtask

	always @(posedge hdmi_pixClk)
		if (u_soc_fabric.u_fabric_assert.tripped)
			stop_with_failure("A concurrent assertion on the fabric ports failed");

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge hdmi_pixClk);
		stop_with_failure("Timeout: the tests did not finish in the expected time");
	end

	initial begin
		rst_n = 1'b0;
		repeat (5) @(posedge hdmi_pixClk);
		rst_n <= 1'b1;
		run_arbitration();
		run_boot();
		run_external();
		run_unmapped();
		repeat (4) @(posedge hdmi_pixClk);
		if (u_soc_fabric.u_fabric_assert.tripped) begin
			stop_with_failure("A concurrent assertion on the fabric ports failed");
		end else begin
			$display("Done: no errors");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* soc_fabric.f */
hdl/axil_pkg.sv
hdl/soc_map_pkg.sv
hdl/reset_release.sv
hdl/axil_arbiter.sv
hdl/axil_addr_router.sv
hdl/boot_ram.sv
hdl/soc_fabric.sv
sim/soc_fabric_assert.sv
sim/tb_soc_fabric.sv

/* Bender.yml */
package:
  name: soc_fabric

sources:
  - hdl/axil_pkg.sv
  - hdl/soc_map_pkg.sv
  - hdl/reset_release.sv
  - hdl/axil_arbiter.sv
  - hdl/axil_addr_router.sv
  - hdl/boot_ram.sv
  - hdl/soc_fabric.sv
  - target: simulation
    files:
      - sim/soc_fabric_assert.sv
      - sim/tb_soc_fabric.sv
